// ==== hw/fetch_pkg.sv ====
// shared fetch subsystem constants, cache geometry and state enums

package fetch_pkg;

	// program counter value after reset
	// instruction memory begins here
	localparam logic [31:0] RESET_PC = 32'h0600_2000;

	// no-operation encoding
	// major opcode 01111 in the top five bits, all other bits zero
	localparam logic [31:0] NOP_INSTR = {5'b01111, 27'd0};

	// cache line geometry
	// one line is sixteen 32-bit words
	localparam int LINE_WORDS = 16;
	localparam int LINE_BITS = LINE_WORDS * 32;

	// direct mapped with eight sets
	localparam int CACHE_LINES = 8;

	// address split, from the top: tag | index | word offset | byte offset
	localparam int INDEX_BITS = 3;
	localparam int OFFSET_BITS = 4;
	// the low two bits pick a byte inside a word and are never used by fetch
	localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS - 2;

	// icache controller states
	typedef enum logic {
		IDLE_LOOKUP,
		WAIT_FILL
	} cache_state_e;

	// line fill engine states
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_BEAT,
		FILL_DONE
	} fill_state_e;

endpackage

// ==== hw/fetch.sv ====
// fetch stage: program counter register, next pc selection, instruction source mux

`timescale 1ns/1ps

module fetch (
	input  logic        clk,
	input  logic        rst_n,
	// next pc computed by the core (pc + 4 or a branch target)
	input  logic [31:0] in_pc_next,
	input  logic        stall,
	input  logic        flush,
	// return from interrupt
	input  logic        restore,
	input  logic [31:0] pc_before_int,
	// injected instruction from the cpu interrupt FSM
	input  logic        use_cpu_injection,
	input  logic [31:0] cpu_injection,
	// injected instruction from the interrupt controller
	input  logic        use_int_instr,
	input  logic [31:0] int_instr,
	// word read from the icache at pc
	input  logic [31:0] rd_data,
	output logic [31:0] pc,
	output logic [31:0] instr
);

	logic [31:0] pc_next;
	logic        pc_hold;

	// hold only on stall without flush
	// a flush means a taken branch, so the pc must move even when stalled
	//   flush stall | update
	//     0     0   |   1
	//     0     1   |   0
	//     1     0   |   1
	//     1     1   |   1
	assign pc_hold = stall & ~flush;

	// restore wins over everything else
	always_comb begin
		if (restore) begin
			pc_next = pc_before_int;
		end else if (pc_hold) begin
			pc_next = pc;
		end else begin
			pc_next = in_pc_next;
		end
	end

	// program counter register, updated on every edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= fetch_pkg::RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// instruction source priority
	// flush squashes to a NOP, then the two injections, then memory
	// injections also cover a miss still in flight, rd_data is ignored then
	always_comb begin
		if (flush) begin
			instr = fetch_pkg::NOP_INSTR;
		end else if (use_cpu_injection) begin
			instr = cpu_injection;
		end else if (use_int_instr) begin
			instr = int_instr;
		end else begin
			// plain fetch from the icache
			instr = rd_data;
		end
	end

endmodule

// ==== hw/icache.sv ====
// direct mapped instruction cache: tag, valid and line arrays, hit logic, miss FSM

`timescale 1ns/1ps

module icache (
	input  logic                           clk,
	input  logic                           rst_n,
	// fetch address, presented every cycle
	input  logic [31:0]                    pc,
	// line returned by the fill engine
	input  logic [fetch_pkg::LINE_BITS-1:0] fill_line,
	input  logic                           fill_done,
	output logic [31:0]                    rd_data,
	output logic                           done,
	// fill request, held until fill_done
	output logic                           fill_req,
	output logic [31:0]                    fill_addr
);

	// field positions inside a byte address
	localparam int OFF_LSB = 2;
	localparam int IDX_LSB = OFF_LSB + fetch_pkg::OFFSET_BITS;
	localparam int TAG_LSB = IDX_LSB + fetch_pkg::INDEX_BITS;

	// a line viewed as an array of words
	typedef logic [fetch_pkg::LINE_WORDS-1:0][31:0] line_t;

	fetch_pkg::cache_state_e state;
	fetch_pkg::cache_state_e state_next;

	// storage arrays
	logic [fetch_pkg::TAG_BITS-1:0] tag_mem [fetch_pkg::CACHE_LINES];
	line_t                          line_mem [fetch_pkg::CACHE_LINES];
	logic [fetch_pkg::CACHE_LINES-1:0] valid;

	// current lookup fields
	logic [fetch_pkg::TAG_BITS-1:0]    pc_tag;
	logic [fetch_pkg::INDEX_BITS-1:0]  pc_index;
	logic [fetch_pkg::OFFSET_BITS-1:0] pc_offset;
	logic                              hit;

	// set being filled, taken from the latched line address
	logic [fetch_pkg::TAG_BITS-1:0]   fill_tag;
	logic [fetch_pkg::INDEX_BITS-1:0] fill_index;

	assign pc_tag    = pc[31:TAG_LSB];
	assign pc_index  = pc[TAG_LSB-1:IDX_LSB];
	assign pc_offset = pc[IDX_LSB-1:OFF_LSB];

	assign fill_tag   = fill_addr[31:TAG_LSB];
	assign fill_index = fill_addr[TAG_LSB-1:IDX_LSB];

	// hit check straight off the flop arrays, same cycle as pc
	assign hit = valid[pc_index] & (tag_mem[pc_index] == pc_tag);

	// word select
	assign rd_data = line_mem[pc_index][pc_offset];

	// no done while a fill is pending
	// after fill_done the next cycle looks up again
	assign done = (state == fetch_pkg::IDLE_LOOKUP) & hit;

	// request stays up for the whole WAIT_FILL stay
	// drops the cycle after fill_done
	assign fill_req = (state == fetch_pkg::WAIT_FILL);

	always_comb begin
		state_next = state;
		case (state)
			fetch_pkg::IDLE_LOOKUP: begin
				if (!hit) begin
					state_next = fetch_pkg::WAIT_FILL;
				end
			end
			fetch_pkg::WAIT_FILL: begin
				// fill is never aborted, even if pc moved meanwhile
				if (fill_done) begin
					state_next = fetch_pkg::IDLE_LOOKUP;
				end
			end
			default: begin
				state_next = fetch_pkg::IDLE_LOOKUP;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= fetch_pkg::IDLE_LOOKUP;
		end else begin
			state <= state_next;
		end
	end

	// line aligned miss address, captured once when the miss is seen
	always_ff @(posedge clk) begin
		if (state == fetch_pkg::IDLE_LOOKUP && !hit) begin
			fill_addr <= {pc[31:IDX_LSB], {IDX_LSB{1'b0}}};
		end
	end

	// valid bits start clear
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (state == fetch_pkg::WAIT_FILL && fill_done) begin
			valid[fill_index] <= 1'b1;
		end
	end

	// install tag and line in the fill_done cycle
	always_ff @(posedge clk) begin
		if (state == fetch_pkg::WAIT_FILL && fill_done) begin
			tag_mem[fill_index]  <= fill_tag;
			line_mem[fill_index] <= fill_line;
		end
	end

endmodule

// ==== hw/line_fill.sv ====
// line fill engine: Wishbone classic read master assembling one cache line from 16 beats

`timescale 1ns/1ps

module line_fill (
	input  logic                           clk,
	input  logic                           rst_n,
	// request from the icache, line aligned address
	input  logic                           fill_req,
	input  logic [31:0]                    fill_addr,
	// Wishbone read data and acknowledge
	input  logic [31:0]                    wb_dat_i,
	input  logic                           wb_ack,
	output logic [fetch_pkg::LINE_BITS-1:0] fill_line,
	output logic                           fill_done,
	// Wishbone classic master outputs
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [31:0]                    wb_adr
);

	fetch_pkg::fill_state_e state;

	// beat counter, also the word position inside the line
	logic [fetch_pkg::OFFSET_BITS-1:0] beat;
	logic                              last_beat;

	// line buffer, one word per beat
	logic [fetch_pkg::LINE_WORDS-1:0][31:0] line_buf;

	assign last_beat = (beat == fetch_pkg::OFFSET_BITS'(fetch_pkg::LINE_WORDS - 1));

	// cyc and stb together for the full burst
	assign wb_cyc = (state == fetch_pkg::FILL_BEAT);
	assign wb_stb = (state == fetch_pkg::FILL_BEAT);
	// read only master
	assign wb_we = 1'b0;

	// one cycle pulse after the sixteenth ack
	assign fill_done = (state == fetch_pkg::FILL_DONE);
	assign fill_line = line_buf;

	// control: state, beat count and bus address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= fetch_pkg::FILL_IDLE;
			beat   <= '0;
			wb_adr <= '0;
		end else begin
			case (state)
				fetch_pkg::FILL_IDLE: begin
					if (fill_req) begin
						state  <= fetch_pkg::FILL_BEAT;
						beat   <= '0;
						wb_adr <= fill_addr;
					end
				end
				fetch_pkg::FILL_BEAT: begin
					// wait states from the slave just hold everything
					if (wb_ack) begin
						beat   <= beat + 1'b1;
						wb_adr <= wb_adr + 32'd4;
						if (last_beat) begin
							state <= fetch_pkg::FILL_DONE;
						end
					end
				end
				fetch_pkg::FILL_DONE: begin
					// icache drops fill_req on the next edge
					state <= fetch_pkg::FILL_IDLE;
				end
				default: begin
					state <= fetch_pkg::FILL_IDLE;
				end
			endcase
		end
	end

	// capture each acked word at its beat position
	always_ff @(posedge clk) begin
		if (state == fetch_pkg::FILL_BEAT && wb_ack) begin
			line_buf[beat] <= wb_dat_i;
		end
	end

endmodule

// ==== hw/fetch_top.sv ====
// fetch subsystem top: fetch stage, instruction cache and Wishbone line fill

`timescale 1ns/1ps

module fetch_top (
	input  logic        clk,
	input  logic        rst_n,
	// core side
	input  logic [31:0] in_pc_next,
	input  logic        stall,
	input  logic        flush,
	input  logic        restore,
	input  logic [31:0] pc_before_int,
	input  logic        use_cpu_injection,
	input  logic [31:0] cpu_injection,
	input  logic        use_int_instr,
	input  logic [31:0] int_instr,
	output logic [31:0] instr,
	output logic [31:0] pc_out,
	output logic        done,
	// Wishbone classic master
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [31:0] wb_adr,
	input  logic [31:0] wb_dat_i,
	input  logic        wb_ack
);

	// icache read word
	logic [31:0] rd_data;

	// icache to line fill handshake
	logic                           fill_req;
	logic [31:0]                    fill_addr;
	logic [fetch_pkg::LINE_BITS-1:0] fill_line;
	logic                           fill_done;

	// pc_out is the fetch pc itself, no extra stage
	fetch u_fetch (
		.clk               (clk),
		.rst_n             (rst_n),
		.in_pc_next        (in_pc_next),
		.stall             (stall),
		.flush             (flush),
		.restore           (restore),
		.pc_before_int     (pc_before_int),
		.use_cpu_injection (use_cpu_injection),
		.cpu_injection     (cpu_injection),
		.use_int_instr     (use_int_instr),
		.int_instr         (int_instr),
		.rd_data           (rd_data),
		.pc                (pc_out),
		.instr             (instr)
	);

	icache u_icache (
		.clk       (clk),
		.rst_n     (rst_n),
		.pc        (pc_out),
		.fill_line (fill_line),
		.fill_done (fill_done),
		.rd_data   (rd_data),
		.done      (done),
		.fill_req  (fill_req),
		.fill_addr (fill_addr)
	);

	line_fill u_line_fill (
		.clk       (clk),
		.rst_n     (rst_n),
		.fill_req  (fill_req),
		.fill_addr (fill_addr),
		.wb_dat_i  (wb_dat_i),
		.wb_ack    (wb_ack),
		.fill_line (fill_line),
		.fill_done (fill_done),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr)
	);

endmodule

// ==== verif/fetch_properties.sv ====
// Wishbone master and reset assertions, bound into the line fill engine

`timescale 1ns/1ps

module fetch_properties (
	input logic        clk,
	input logic        rst_n,
	input logic        wb_cyc,
	input logic        wb_stb,
	input logic        wb_ack,
	input logic [31:0] wb_adr
);

	// number of assertion failures so far
	int failures = 0;

	// a strobe outside a bus cycle is illegal
	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
		else begin
			$error("wb_stb high while wb_cyc is low");
			failures++;
		end

	// master holds the address through wait states
	adr_held: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_stb && !wb_ack) |=> $stable(wb_adr))
		else begin
			$error("wb_adr changed during a wait state");
			failures++;
		end

	// no bus cycle while in reset
	cyc_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_cyc)
		else begin
			$error("wb_cyc high during reset");
			failures++;
		end

endmodule

// ==== verif/fetch_checker.sv ====
// fetch checker with per-row compare, filled-line hit watch, burst count and closing summary

`timescale 1ns/1ps

module fetch_checker (
	input  logic        clk,
	input  logic        rst_n,
	// vector row under test while step_valid is high
	input  logic        step_valid,
	input  int          row_num,
	input  logic [3:0]  op,
	input  logic [31:0] operand,
	input  logic [31:0] exp_pc,
	input  logic [1:0]  src,
	input  logic        end_run,
	// DUT ports under watch
	input  logic [31:0] pc_out,
	input  logic [31:0] instr,
	input  logic        done,
	input  logic        wb_cyc,
	input  logic        wb_we,
	output int          error_count
);

	int          tests;
	int          passed;
	int          bursts;
	logic        cyc_q;
	logic        rst_q;
	logic        reported;
	// 64-byte line addresses touched by the pc and seen with done high
	logic [25:0] touched[$];
	logic [25:0] filled[$];

	// expected word from the memory rule, the NOP encoding or the injected operand
	function automatic logic [31:0] expected_instr(input logic [1:0] s, input logic [31:0] opnd,
			input logic [31:0] addr);
		case (s)
			2'd0: return addr ^ 32'hA5A5_0000;
			// major opcode 01111 in the top five bits
			2'd1: return 32'h7800_0000;
			default: return opnd;
		endcase
	endfunction

	function automatic string op_name(input logic [3:0] code);
		case (code)
			4'd0: return "seq";
			4'd1: return "branch";
			4'd2: return "stall";
			4'd3: return "restore";
			4'd4: return "cpu_inject";
			default: return "int_inject";
		endcase
	endfunction

	function automatic bit in_list(input logic [25:0] list[$], input logic [25:0] line);
		foreach (list[i]) begin
			if (list[i] == line) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// first edge out of reset expects the reset pc, an idle bus and nothing cached
	task automatic check_reset_state();
		if (pc_out !== 32'h0600_2000 || wb_cyc !== 1'b0 || done !== 1'b0) begin
			$display("Mismatch at %0t: after reset pc_out %h wb_cyc %b done %b", $time,
				pc_out, wb_cyc, done);
			error_count++;
		end
	endtask

	task automatic check_row();
		logic        bad;
		logic [31:0] want;
		bad = 1'b0;
		want = expected_instr(src, operand, exp_pc);
		tests++;
		if (pc_out !== exp_pc) begin
			$display("Mismatch at %0t: test %0d pc_out %h, expected %h", $time, row_num,
				pc_out, exp_pc);
			bad = 1'b1;
		end
		if (instr !== want) begin
			$display("Mismatch at %0t: test %0d instr %h, expected %h", $time, row_num,
				instr, want);
			bad = 1'b1;
		end
		if (!in_list(touched, pc_out[31:6])) begin
			touched.push_back(pc_out[31:6]);
		end
		if (done === 1'b1 && !in_list(filled, pc_out[31:6])) begin
			filled.push_back(pc_out[31:6]);
		end
		if (bad) begin
			error_count++;
			$display("test %0d %s: fail", row_num, op_name(op));
		end else begin
			passed++;
			$display("test %0d %s: pass", row_num, op_name(op));
		end
	endtask

	// one burst per distinct line and no refetch of a line already held
	task automatic close_run();
		if (bursts != touched.size()) begin
			$display("Mismatch at %0t: %0d Wishbone bursts for %0d distinct lines", $time,
				bursts, touched.size());
			error_count++;
		end
		$display("tests %0d, passed %0d, failed %0d, bursts %0d, errors %0d", tests, passed,
			tests - passed, bursts, error_count);
		reported = 1'b1;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			error_count = 0;
			tests = 0;
			passed = 0;
			bursts = 0;
			reported = 1'b0;
			touched.delete();
			filled.delete();
		end else begin
			if (!rst_q) begin
				check_reset_state();
			end
			if (wb_cyc && !cyc_q) begin
				bursts++;
			end
			// read only master
			if (wb_we !== 1'b0) begin
				$display("Mismatch at %0t: wb_we %b, expected 0", $time, wb_we);
				error_count++;
			end
			// a pc inside a held line must hit in the same cycle
			if (in_list(filled, pc_out[31:6]) && done !== 1'b1) begin
				$display("Mismatch at %0t: pc %h is in a filled line but done is low",
					$time, pc_out);
				error_count++;
			end
			if (step_valid) begin
				check_row();
			end
			if (end_run && !reported) begin
				close_run();
			end
		end
		cyc_q = wb_cyc;
		rst_q = rst_n;
	end

endmodule

// ==== verif/tb_fetch_top.sv ====
// testbench top with clock, reset, vector driven stimulus, Wishbone memory model and watchdog

`timescale 1ns/1ps

module tb_fetch_top;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ROWS = 16;
	// cycles allowed per row
	localparam int ROW_CYCLES = 16 * 4 + 8;

	// operation codes in the vector file
	localparam logic [3:0] OP_SEQ = 4'd0;
	localparam logic [3:0] OP_BRANCH = 4'd1;
	localparam logic [3:0] OP_STALL = 4'd2;
	localparam logic [3:0] OP_RESTORE = 4'd3;
	localparam logic [3:0] OP_CPU = 4'd4;
	localparam logic [3:0] OP_INT = 4'd5;

	logic        clk;
	logic        rst_n;
	logic [31:0] in_pc_next;
	logic        stall;
	logic        flush;
	logic        restore;
	logic [31:0] pc_before_int;
	logic        use_cpu_injection;
	logic [31:0] cpu_injection;
	logic        use_int_instr;
	logic [31:0] int_instr;
	logic [31:0] instr;
	logic [31:0] pc_out;
	logic        done;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_i = 32'd0;
	logic        wb_ack = 1'b0;

	// four words per row for op, operand, expected pc and expected source
	logic [31:0] vec_mem [NUM_ROWS*4];

	// row handed to the checker
	logic        step_valid;
	int          cur_row;
	logic [3:0]  cur_op;
	logic [31:0] cur_operand;
	logic [31:0] cur_pc;
	logic [1:0]  cur_src;
	logic        end_run;
	int          check_errors;

	// memory model wait state source
	logic [15:0] lfsr = 16'd99;
	logic [1:0]  wait_left = 2'd0;

	fetch_top UUT (.*);

	fetch_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.step_valid  (step_valid),
		.row_num     (cur_row),
		.op          (cur_op),
		.operand     (cur_operand),
		.exp_pc      (cur_pc),
		.src         (cur_src),
		.end_run     (end_run),
		.pc_out      (pc_out),
		.instr       (instr),
		.done        (done),
		.wb_cyc      (wb_cyc),
		.wb_we       (wb_we),
		.error_count (check_errors)
	);

	bind line_fill fetch_properties u_wb_props (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_ack (wb_ack),
		.wb_adr (wb_adr)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// two LFSR steps give 0 to 3 wait states
	task draw_wait_states();
		wait_left[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		wait_left[1] = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	// Wishbone slave returning the address xor A5A5_0000 as the word
	always @(negedge clk) begin
		if (!rst_n) begin
			wb_ack = 1'b0;
			lfsr = 16'd99;
			draw_wait_states();
		end else if (wb_ack) begin
			// beat taken on the last rising edge
			wb_ack = 1'b0;
			draw_wait_states();
		end else if (wb_cyc && wb_stb) begin
			if (wait_left == 2'd0) begin
				wb_dat_i = wb_adr ^ 32'hA5A5_0000;
				wb_ack = 1'b1;
			end else begin
				wait_left = wait_left - 2'd1;
			end
		end
	end

	// core side at rest with the pc held
	task drive_idle();
		in_pc_next = 32'd0;
		stall = 1'b1;
		flush = 1'b0;
		restore = 1'b0;
		pc_before_int = 32'd0;
		use_cpu_injection = 1'b0;
		cpu_injection = 32'd0;
		use_int_instr = 1'b0;
		int_instr = 32'd0;
	endtask

	task automatic apply_row(input int row);
		logic [3:0]  op;
		logic [31:0] operand;
		op = vec_mem[row*4][3:0];
		operand = vec_mem[row*4+1];
		cur_row = row;
		cur_op = op;
		cur_operand = operand;
		cur_pc = vec_mem[row*4+2];
		cur_src = vec_mem[row*4+3][1:0];
		case (op)
			OP_SEQ: begin
				in_pc_next = pc_out + 32'd4;
				stall = ~done;
			end
			OP_BRANCH: begin
				// taken branch with flush over stall
				in_pc_next = operand;
				flush = 1'b1;
				stall = 1'b1;
			end
			OP_STALL: begin
				in_pc_next = pc_out + 32'd4;
				stall = 1'b1;
			end
			OP_RESTORE: begin
				in_pc_next = pc_out + 32'd4;
				pc_before_int = operand;
				restore = 1'b1;
				flush = 1'b1;
				stall = 1'b1;
			end
			OP_CPU: begin
				use_cpu_injection = 1'b1;
				cpu_injection = operand;
				use_int_instr = 1'b1;
				int_instr = ~operand;
			end
			default: begin
				use_int_instr = 1'b1;
				int_instr = operand;
				cpu_injection = ~operand;
			end
		endcase
		step_valid = 1'b1;
	endtask

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + NUM_ROWS * ROW_CYCLES));
		$display("Watchdog expired: the run did not finish in time");
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		end_run = 1'b0;
		step_valid = 1'b0;
		cur_row = 0;
		cur_op = 4'd0;
		cur_operand = 32'd0;
		cur_pc = 32'd0;
		cur_src = 2'd0;
		drive_idle();
		$readmemh("verif/fetch_vectors.txt", vec_mem);
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		for (int row = 0; row < NUM_ROWS; row++) begin
			// injections go in at once even over a pending miss
			if (vec_mem[row*4][3:0] != OP_CPU && vec_mem[row*4][3:0] != OP_INT) begin
				while (!done) begin
					@(negedge clk);
				end
			end
			apply_row(row);
			@(negedge clk);
			step_valid = 1'b0;
			drive_idle();
		end
		end_run = 1'b1;
		@(posedge clk);
		@(negedge clk);
		if (check_errors == 0 && UUT.u_line_fill.u_wb_props.failures == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== fetch_unit.f ====
hw/fetch_pkg.sv
hw/fetch.sv
hw/icache.sv
hw/line_fill.sv
hw/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_checker.sv
verif/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  # package first, then the RTL bottom up
  - hw/fetch_pkg.sv
  - hw/fetch.sv
  - hw/icache.sv
  - hw/line_fill.sv
  - hw/fetch_top.sv
  - target: simulation
    files:
      - verif/fetch_properties.sv
      - verif/fetch_checker.sv
      - verif/tb_fetch_top.sv

// ==== verif/fetch_vectors.txt ====
// columns: op, operand, expected pc_out, expected instr source (all hex)
// op 0 seq 1 branch 2 stall 3 restore 4 cpu_inject 5 int_inject; source 0 mem 1 nop 2 cpu 3 int
0 00000000 06002000 0
0 00000000 06002004 0
2 00000000 06002008 0
0 00000000 06002008 0
1 0600203C 0600200C 1
0 00000000 0600203C 0
4 12345678 06002040 2
5 0BADF00D 06002040 3
0 00000000 06002040 0
1 06002010 06002044 1
0 00000000 06002010 0
3 06002100 06002014 1
0 00000000 06002100 0
1 06002048 06002104 1
4 CAFE0001 06002048 2
2 00000000 06002048 0
